// ==== dv/sdctrl_assert.sv ====
// ================================================
// protocol checks bound into sdctrl_top
// err_count is read by the testbench at the end
// ================================================
`timescale 1ns/1ps
`default_nettype none

module sdctrl_assert import sdctrl_pkg::*; (
    input wire             i_clk,
    input wire             i_nrst,
    input wire             i_pready,
    input wire             i_cmd_valid,
    input wire             i_cmd_ready,
    input wire cmd_index_t i_cmd_index,
    input wire cmd_arg_t   i_cmd_arg,
    input wire             i_cmd_line,            // o_sd_cmd of the top
    input wire tx_state_t  i_tx_state
);

    int err_count = 0;                            // failed assertion count

    pready_single: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_pready |=> !i_pready)
        else begin
            err_count++;
            $error("o_pready high in two consecutive cycles");
        end

    // payload frozen until the transmitter takes it
    cmd_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_cmd_valid && !i_cmd_ready) |=>
            (i_cmd_valid && $stable(i_cmd_index) && $stable(i_cmd_arg)))
        else begin
            err_count++;
            $error("command request changed or dropped before ready");
        end

    idle_line_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_tx_state == TX_IDLE) |-> i_cmd_line)
        else begin
            err_count++;
            $error("CMD line low while the transmitter is idle");
        end

endmodule

`default_nettype wire

// ==== dv/sdctrl_tb.sv ====
// ================================================
// testbench for sdctrl_top, APB register table, sck rate,
// LFSR command frames, back-pressure and overrun
// the monitor samples CMD on rising sck like a card
// stops at the first mismatch
// ================================================
`timescale 1ns/1ps
`default_nettype none

`include "sdctrl_map.svh"

module sdctrl_tb import sdctrl_pkg::*; ();

    localparam int        CLK_PERIOD = 40;
    localparam int        SCK_DIV    = 3;           // divider used for frames
    localparam int        TBL_LEN    = 19;
    localparam int        XFER_CLKS  = 6;           // setup, two access, idle, margin
    localparam int        FRAME_CLKS = 96 * (SCK_DIV + 1);
    localparam int        WDOG_CLKS  = (TBL_LEN + 40) * XFER_CLKS + 9 * FRAME_CLKS + 500;
    localparam reg_data_t ALL        = 32'hFFFF_FFFF;

    typedef struct packed {
        logic      wr;
        reg_addr_t addr;
        reg_data_t wdata;
        reg_data_t mask;                            // bits compared on a read
        reg_data_t exp;
        logic      err;                             // expected pslverr
    } apb_entry_t;

    localparam apb_entry_t REG_TABLE [TBL_LEN] = '{
        '{1'b0, `REG_SCKDIV,    32'h0,          ALL,      32'h0,          1'b0},
        '{1'b0, `REG_CONTROL,   32'h0,          ALL,      32'h10,         1'b0}, // line idles high
        '{1'b0, `REG_CMD_ARG,   32'h0,          ALL,      32'h0,          1'b0},
        '{1'b0, `REG_CMD_START, 32'h0,          ALL,      32'h0,          1'b0},
        '{1'b0, `REG_STATUS,    32'h0,          ALL,      32'h0,          1'b0},
        '{1'b1, `REG_SCKDIV,    32'h1234_0005,  32'h0,    32'h0,          1'b0},
        '{1'b0, `REG_SCKDIV,    32'h0,          ALL,      32'h5,          1'b0}, // 16 bits kept
        '{1'b1, `REG_CMD_ARG,   32'hA5C3_0F96,  32'h0,    32'h0,          1'b0},
        '{1'b0, `REG_CMD_ARG,   32'h0,          ALL,      32'hA5C3_0F96,  1'b0},
        '{1'b1, `REG_CONTROL,   32'h3,          32'h0,    32'h0,          1'b0},
        '{1'b0, `REG_CONTROL,   32'h0,          ALL,      32'h11,         1'b0}, // clear reads 0
        '{1'b1, `REG_CONTROL,   32'h0,          32'h0,    32'h0,          1'b0},
        '{1'b0, 12'h008,        32'h0,          ALL,      32'h0,          1'b0}, // hole
        '{1'b0, 12'h002,        32'h0,          ALL,      32'h0,          1'b0},
        '{1'b0, 12'h018,        32'h0,          32'h0,    32'h0,          1'b1}, // past REG_LAST
        '{1'b0, 12'hFFC,        32'h0,          32'h0,    32'h0,          1'b1},
        '{1'b1, `REG_STATUS,    32'hFFFF,       32'h0,    32'h0,          1'b1}, // read only
        '{1'b1, 12'h040,        32'h1,          32'h0,    32'h0,          1'b1},
        '{1'b0, `REG_STATUS,    32'h0,          ALL,      32'h0,          1'b0}
    };

    logic        i_clk;
    logic        i_nrst;
    logic        i_psel;
    logic        i_penable;
    logic        i_pwrite;
    reg_addr_t   i_paddr;
    reg_data_t   i_pwdata;
    logic        o_pready;
    reg_data_t   o_prdata;
    logic        o_pslverr;
    logic        i_sd_cmd;
    logic        o_sd_clk;
    logic        o_sd_cmd;
    logic        o_sd_busy;
    logic [31:0] lfsr_q = 32'h45764e3a;
    logic [47:0] frame_mem [0:7];                   // captured frames, MSB first
    int          frames_seen = 0;

    sdctrl_top #(
        .ADDR_BITS (12)
    ) sdctrl_top_i (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_pready  (o_pready),
        .o_prdata  (o_prdata),
        .o_pslverr (o_pslverr),
        .i_sd_cmd  (i_sd_cmd),
        .o_sd_clk  (o_sd_clk),
        .o_sd_cmd  (o_sd_cmd),
        .o_sd_busy (o_sd_busy)
    );

    bind sdctrl_top sdctrl_assert assert_i (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_pready    (o_pready),
        .i_cmd_valid (cmd_if.cmd_valid),
        .i_cmd_ready (cmd_if.cmd_ready),
        .i_cmd_index (cmd_if.cmd_index),
        .i_cmd_arg   (cmd_if.cmd_arg),
        .i_cmd_line  (o_sd_cmd),
        .i_tx_state  (tx_state)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin : watchdog
        repeat (WDOG_CLKS) @(posedge i_clk);
        fail_stop("watchdog expired, the DUT stopped making progress");
    end

    // card side, start bit opens a frame
    initial begin : frame_monitor
        logic [47:0] frame_bits;
        forever begin
            @(posedge o_sd_clk);
            if (o_sd_cmd === 1'b0) begin
                frame_bits = '0;                    // start bit in bit 0 for now
                for (int b = 1; b < CMD_FRAME_BITS; b++) begin
                    @(posedge o_sd_clk);
                    frame_bits = {frame_bits[46:0], o_sd_cmd};
                end
                frame_mem[frames_seen[2:0]] = frame_bits;
                frames_seen++;
            end
        end
    end

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_data(input reg_data_t got, input reg_data_t exp, input string what);
        if (got !== exp) begin
            fail_stop($sformatf("** Error at %0d ns: %s got %h expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_stop($sformatf("** Error at %0d ns: %s got %b expected %b",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_frame(input cmd_arg_t got_arg, input crc7_t got_crc,
                               input cmd_arg_t exp_arg, input crc7_t exp_crc);
        if (got_arg !== exp_arg || got_crc !== exp_crc) begin
            fail_stop($sformatf("** Error at %0d ns: frame arg %h crc %h expected %h crc %h",
                                $time, got_arg, got_crc, exp_arg, exp_crc));
        end
    endtask

    // remainder of data * x^7 divided by x^7+x^3+1
    function automatic crc7_t crc7_calc(input logic [39:0] data);
        logic [46:0] rem;
        rem = {data, 7'b0};
        for (int i = 46; i >= 7; i--) begin
            if (rem[i]) rem[i -: 8] = rem[i -: 8] ^ 8'h89;
        end
        return rem[6:0];
    endfunction

    // x^32 + x^22 + x^2 + x + 1, shift left
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic lfsr_take(input int n, output logic [31:0] val);
        val = '0;
        repeat (n) begin
            lfsr_q = lfsr_next(lfsr_q);             // one step per bit
            val    = {val[30:0], lfsr_q[0]};
        end
    endtask

    task automatic apb_xfer(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
                            output reg_data_t rdata, output logic err);
        int n;
        @(posedge i_clk);
        i_psel    <= 1'b1;                          // setup phase
        i_penable <= 1'b0;
        i_pwrite  <= wr;
        i_paddr   <= addr;
        i_pwdata  <= wdata;
        @(posedge i_clk);
        i_penable <= 1'b1;
        n = 0;
        @(negedge i_clk);
        while (o_pready !== 1'b1) begin
            if (n == 8) fail_stop("APB transfer never got pready");
            n++;
            @(negedge i_clk);
        end
        rdata = o_prdata;                           // mid-cycle, stable
        err   = o_pslverr;
        @(posedge i_clk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        reg_data_t rd;
        logic      err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_bit(err, 1'b0, "pslverr on write");
    endtask

    task automatic reg_read(input reg_addr_t addr, input reg_data_t mask,
                            input reg_data_t exp, input string what);
        reg_data_t rd;
        logic      err;
        apb_xfer(1'b0, addr, 32'h0, rd, err);
        check_bit(err, 1'b0, "pslverr on read");
        check_data(rd & mask, exp, what);
    endtask

    task automatic send_cmd(input cmd_index_t idx, input cmd_arg_t arg);
        reg_write(`REG_CMD_ARG, arg);
        reg_write(`REG_CMD_START, reg_data_t'(idx));
    endtask

    task automatic verify_frame(input int k, input cmd_index_t idx, input cmd_arg_t arg);
        logic [47:0] f;
        f = frame_mem[k];
        check_bit(f[46], 1'b1, "transmission bit");
        check_data(reg_data_t'(f[45:40]), reg_data_t'(idx), "command index");
        check_frame(f[39:8], f[7:1], arg, crc7_calc({2'b01, idx, arg}));
        check_bit(f[0], 1'b1, "end bit");
    endtask

    task automatic wait_idle();
        @(negedge i_clk);
        while (o_sd_busy !== 1'b0) @(negedge i_clk);
    endtask

    initial begin : main_seq
        cmd_index_t  idx [0:5];
        cmd_arg_t    arg [0:5];
        logic [31:0] rnd;
        realtime     t0;
        realtime     t1;
        logic        held;
        reg_data_t   rd;
        logic        err;
        i_nrst    <= 1'b0;
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
        i_pwrite  <= 1'b0;
        i_paddr   <= '0;
        i_pwdata  <= '0;
        i_sd_cmd  <= 1'b1;                          // pulled up line
        repeat (2) @(posedge i_clk);
        i_nrst <= 1'b1;
        @(negedge i_clk);
        check_bit(o_sd_cmd, 1'b1, "o_sd_cmd after reset");
        check_bit(o_sd_clk, 1'b0, "o_sd_clk after reset");
        check_bit(o_sd_busy, 1'b0, "o_sd_busy after reset");

        for (int i = 0; i < TBL_LEN; i++) begin
            apb_xfer(REG_TABLE[i].wr, REG_TABLE[i].addr, REG_TABLE[i].wdata, rd, err);
            check_bit(err, REG_TABLE[i].err, $sformatf("pslverr of entry %0d", i));
            check_data(rd & REG_TABLE[i].mask, REG_TABLE[i].exp,
                       $sformatf("read data of entry %0d", i));
        end

        // sck period, rising to rising
        reg_write(`REG_SCKDIV, SCK_DIV);
        reg_write(`REG_CONTROL, 32'h1);
        @(posedge o_sd_clk);
        t0 = $realtime;
        @(posedge o_sd_clk);
        t1 = $realtime;
        check_data(reg_data_t'(int'(t1 - t0)), reg_data_t'(2 * (SCK_DIV + 1) * CLK_PERIOD),
                   "sck period in ns");
        reg_write(`REG_CONTROL, 32'h0);
        @(negedge i_clk);
        held = o_sd_clk;
        repeat (8 * (SCK_DIV + 1)) begin
            @(negedge i_clk);
            check_bit(o_sd_clk, held, "o_sd_clk with sck disabled");
        end

        reg_write(`REG_CONTROL, 32'h1);
        for (int k = 0; k < 6; k++) begin
            lfsr_take(6, rnd);
            idx[k] = rnd[5:0];
            lfsr_take(32, rnd);
            arg[k] = rnd;
        end
        for (int k = 0; k < 4; k++) begin
            send_cmd(idx[k], arg[k]);
            wait (frames_seen == k + 1);
            verify_frame(k, idx[k], arg[k]);
        end
        wait_idle();
        reg_read(`REG_STATUS, 32'hFF1F, 32'h0400, "status after four commands");

        // sck stopped, transmitter takes the first and parks on the edge
        reg_write(`REG_CONTROL, 32'h0);
        send_cmd(idx[4], arg[4]);
        reg_read(`REG_CONTROL, 32'h100, 32'h100, "busy while waiting for sck");
        @(negedge i_clk);
        check_bit(o_sd_busy, 1'b1, "o_sd_busy while waiting for sck");
        send_cmd(idx[5], arg[5]);                   // held as pending
        reg_read(`REG_CMD_START, 32'h13F, 32'h100 | reg_data_t'(idx[5]), "pending request");
        reg_write(`REG_CMD_START, 32'h3F);          // dropped
        reg_read(`REG_STATUS, 32'h10, 32'h10, "overrun after a dropped start");
        reg_read(`REG_CMD_START, 32'h13F, 32'h100 | reg_data_t'(idx[5]), "request kept");
        reg_write(`REG_CONTROL, 32'h1);
        wait (frames_seen == 6);
        verify_frame(4, idx[4], arg[4]);
        verify_frame(5, idx[5], arg[5]);
        wait_idle();
        reg_read(`REG_CMD_START, 32'h100, 32'h0, "no request left");
        reg_read(`REG_STATUS, 32'hFF10, 32'h0610, "count and overrun");
        repeat (FRAME_CLKS) @(negedge i_clk);       // room for a stray seventh frame
        check_data(reg_data_t'(frames_seen), 32'd6, "frames on the CMD line");
        check_bit(o_sd_busy, 1'b0, "o_sd_busy after the last frame");
        reg_write(`REG_CONTROL, 32'h3);
        reg_read(`REG_STATUS, 32'h10, 32'h0, "overrun after clear");

        // line readback through the synchronizer
        @(posedge i_clk);
        i_sd_cmd <= 1'b0;
        repeat (3) @(posedge i_clk);
        reg_read(`REG_CONTROL, 32'h10, 32'h0, "CMD line low");
        @(posedge i_clk);
        i_sd_cmd <= 1'b1;
        repeat (3) @(posedge i_clk);
        reg_read(`REG_CONTROL, 32'h10, 32'h10, "CMD line high");

        repeat (4) @(posedge i_clk);
        if (sdctrl_top_i.assert_i.err_count != 0) begin
            fail_stop("a bound protocol assertion failed");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== hw/sdctrl_apb_slave.sv ====
// ================================================
// APB slave, no wait states beyond a fixed two
// every transfer is setup plus two access cycles
// address bits at and above ADDR_BITS are ignored
// ================================================
`timescale 1ns/1ps
`default_nettype none

module sdctrl_apb_slave import sdctrl_pkg::*; #(
    parameter int ADDR_BITS = 12                    // window size, 8..12
) (
    input  wire            i_clk,
    input  wire            i_nrst,
    input  wire            i_psel,
    input  wire            i_penable,
    input  wire            i_pwrite,
    input  wire reg_addr_t i_paddr,
    input  wire reg_data_t i_pwdata,
    output logic           o_pready,
    output reg_data_t      o_prdata,
    output logic           o_pslverr,
    sdctrl_bus_if.master   bus
);

    logic setup_ph;                                 // APB setup cycle
    logic req_q;                                    // request pulse
    logic wait_resp;                                // request out, response due

    assign setup_ph = i_psel && !i_penable;

    // phase tracker, one request per setup phase
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            req_q     <= 1'b0;
            wait_resp <= 1'b0;
        end else begin
            req_q <= setup_ph && !wait_resp;        // lands in the first access cycle
            if (req_q) begin
                wait_resp <= 1'b1;
            end else if (bus.resp_valid) begin
                wait_resp <= 1'b0;                  // transfer completes here
            end
        end
    end

    // request payload, APB holds it stable from setup on
    always_ff @(posedge i_clk) begin
        if (setup_ph) begin
            bus.req_addr  <= reg_addr_t'(i_paddr[ADDR_BITS-1:0]);
            bus.req_write <= i_pwrite;
            bus.req_wdata <= i_pwdata;
        end
    end

    assign bus.req_valid = req_q;

    // response is registered in the register file, second access cycle
    assign o_pready  = wait_resp && bus.resp_valid;
    assign o_prdata  = bus.resp_rdata;
    assign o_pslverr = o_pready && bus.resp_err;    // only meaningful with pready

endmodule

`default_nettype wire

// ==== hw/sdctrl_bus_if.sv ====
// ================================================
// internal buses of the SD controller
// register bus: one request, response next cycle
// command bus: valid/ready, payload held while valid
// ================================================
`timescale 1ns/1ps
`default_nettype none

interface sdctrl_bus_if import sdctrl_pkg::*; ();
    logic      req_valid;               // one-cycle request pulse
    reg_addr_t req_addr;
    logic      req_write;
    reg_data_t req_wdata;
    logic      resp_valid;              // exactly one cycle after req_valid
    reg_data_t resp_rdata;
    logic      resp_err;

    modport master (output req_valid, req_addr, req_write, req_wdata,
                    input  resp_valid, resp_rdata, resp_err);
    modport slave  (input  req_valid, req_addr, req_write, req_wdata,
                    output resp_valid, resp_rdata, resp_err);
endinterface

interface sdctrl_cmd_if import sdctrl_pkg::*; ();
    logic       cmd_valid;
    logic       cmd_ready;              // only high while the transmitter is idle
    cmd_index_t cmd_index;
    cmd_arg_t   cmd_arg;

    modport source (output cmd_valid, cmd_index, cmd_arg, input cmd_ready);
    modport sink   (input  cmd_valid, cmd_index, cmd_arg, output cmd_ready);
endinterface

`default_nettype wire

// ==== hw/sdctrl_cmd_tx.sv ====
// ================================================
// SD command frame transmitter
// bits change on falling sck strobes only, the card
// samples on the next rising edge of sck
// no request is taken while a frame is in flight
// ================================================
`timescale 1ns/1ps
`default_nettype none

module sdctrl_cmd_tx import sdctrl_pkg::*; (
    input  wire        i_clk,
    input  wire        i_nrst,
    input  wire        i_sck_negedge,
    sdctrl_cmd_if.sink cmd,
    output logic       o_sd_cmd,                    // idles high
    output logic       o_busy,
    output tx_state_t  o_state,
    output logic       o_done                       // one clock at frame end
);

    localparam int CRC_FIRST = CMD_FRAME_BITS - 8;  // first CRC bit position
    localparam int END_BIT   = CMD_FRAME_BITS - 1;

    tx_state_t            state;
    logic [5:0]           bit_cnt;                  // next frame bit to drive
    logic [CRC_FIRST-1:0] shreg;                    // start, dir, index, arg
    crc7_t                crc;
    logic                 accept;
    logic                 bit_step;                 // drive one bit this cycle

    function automatic crc7_t crc7_next(input crc7_t c, input logic b);
        logic fb;
        fb = b ^ c[6];
        return {c[5:0], 1'b0} ^ (fb ? CRC7_POLY : 7'h00);
    endfunction

    assign accept   = cmd.cmd_valid && cmd.cmd_ready;
    assign bit_step = i_sck_negedge && (state == TX_WAIT_EDGE || state == TX_SHIFT)
                      && (bit_cnt < 6'(CMD_FRAME_BITS));

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state    <= TX_IDLE;
            bit_cnt  <= '0;
            o_sd_cmd <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (accept) begin
                        state   <= TX_WAIT_EDGE;
                        bit_cnt <= '0;
                    end
                end
                TX_WAIT_EDGE: if (i_sck_negedge) state <= TX_SHIFT;
                TX_SHIFT: begin
                    // last bit has had a full sck period
                    if (i_sck_negedge && bit_cnt == 6'(CMD_FRAME_BITS)) begin
                        state <= TX_DONE;
                    end
                end
                TX_DONE: state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
            if (bit_step) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt < CRC_FIRST) begin
                    o_sd_cmd <= shreg[CRC_FIRST-1];
                end else if (bit_cnt < END_BIT) begin
                    o_sd_cmd <= crc[6];
                end else begin
                    o_sd_cmd <= 1'b1;               // end bit
                end
            end
        end
    end

    // frame payload and running CRC
    always_ff @(posedge i_clk) begin
        if (accept) begin
            shreg <= {1'b0, 1'b1, cmd.cmd_index, cmd.cmd_arg};
            crc   <= '0;
        end else if (bit_step) begin
            if (bit_cnt < CRC_FIRST) begin
                crc   <= crc7_next(crc, shreg[CRC_FIRST-1]);
                shreg <= shreg << 1;
            end else begin
                crc <= crc << 1;                    // CRC goes out MSB first
            end
        end
    end

    assign cmd.cmd_ready = (state == TX_IDLE);
    assign o_busy        = (state != TX_IDLE);
    assign o_state       = state;
    assign o_done        = (state == TX_DONE);

endmodule

`default_nettype wire

// ==== hw/sdctrl_pkg.sv ====
// ================================================
// shared types of the SD command controller
// widths here are fixed, the window size is not
// ================================================
`default_nettype none

package sdctrl_pkg;

    typedef logic [11:0] reg_addr_t;    // APB byte address in the window
    typedef logic [31:0] reg_data_t;    // register data word

    // system clocks per sck half period, minus one
    typedef logic [15:0] sck_div_t;

    typedef logic [5:0]  cmd_index_t;   // SD command index
    typedef logic [31:0] cmd_arg_t;     // SD command argument
    typedef logic [6:0]  crc7_t;        // frame CRC
    typedef logic [7:0]  cmd_count_t;   // completed commands, wraps

    // command transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE      = 2'd0,            // ready for a request
        TX_WAIT_EDGE = 2'd1,            // loaded, waiting for a falling strobe
        TX_SHIFT     = 2'd2,            // frame bits on the line
        TX_DONE      = 2'd3             // one clock, end of frame
    } tx_state_t;

    // start, dir, index, arg, crc, end
    localparam int CMD_FRAME_BITS = 48;

    // x^7 + x^3 + 1 with the x^7 term implied
    localparam crc7_t CRC7_POLY = 7'h09;

endpackage

`default_nettype wire

// ==== hw/sdctrl_regs.sv ====
// ================================================
// register file, sck scaler and command request issue
// sck toggles every divider+1 clocks while enabled
// a start while a request is pending is dropped
// and sets the sticky overrun flag
// ================================================
`timescale 1ns/1ps
`default_nettype none

`include "sdctrl_map.svh"

module sdctrl_regs import sdctrl_pkg::*; #(
    parameter int ADDR_BITS = 12                    // window size, at least 8
) (
    input  wire            i_clk,
    input  wire            i_nrst,
    input  wire            i_sd_cmd,                // CMD line, asynchronous
    sdctrl_bus_if.slave    bus,
    sdctrl_cmd_if.source   cmd,
    output logic           o_sck,
    output logic           o_sck_posedge,           // cycle before sck rises
    output logic           o_sck_negedge,           // cycle before sck falls
    input  wire            i_tx_busy,
    input  wire tx_state_t i_tx_state,
    input  wire            i_tx_done
);

    localparam logic [ADDR_BITS-1:0] A_SCKDIV    = ADDR_BITS'(`REG_SCKDIV);
    localparam logic [ADDR_BITS-1:0] A_CONTROL   = ADDR_BITS'(`REG_CONTROL);
    localparam logic [ADDR_BITS-1:0] A_CMD_ARG   = ADDR_BITS'(`REG_CMD_ARG);
    localparam logic [ADDR_BITS-1:0] A_CMD_START = ADDR_BITS'(`REG_CMD_START);
    localparam logic [ADDR_BITS-1:0] A_STATUS    = ADDR_BITS'(`REG_STATUS);
    localparam logic [ADDR_BITS-1:0] A_LAST      = ADDR_BITS'(`REG_LAST);

    logic [ADDR_BITS-1:0] addr;
    logic       wr_en;                              // legal write this cycle
    logic       start_wr;
    logic       pending;                            // valid and not taken this cycle
    logic       bad_acc;
    reg_data_t  rdata;
    sck_div_t   sck_div;
    sck_div_t   scaler_cnt;
    logic       sclk_ena;
    logic       level;                              // sck level
    logic       tick;                               // sck toggles after this cycle
    cmd_arg_t   arg_reg;                            // firmware view of the argument
    cmd_arg_t   pend_arg;                           // argument of the issued request
    cmd_index_t last_index;
    logic       cmd_valid_q;
    logic       overrun;
    cmd_count_t cmd_count;
    logic [1:0] sd_cmd_sync;                        // 2-flop synchronizer

    assign addr     = bus.req_addr[ADDR_BITS-1:0];
    assign bad_acc  = (addr > A_LAST) || (bus.req_write && addr == A_STATUS);
    assign wr_en    = bus.req_valid && bus.req_write && !bad_acc;
    assign start_wr = wr_en && addr == A_CMD_START;
    assign pending  = cmd_valid_q && !cmd.cmd_ready;

    // read mux, sampled in the request cycle
    always_comb begin
        rdata = '0;
        case (addr)
            A_SCKDIV:    rdata[15:0] = sck_div;
            A_CONTROL: begin
                rdata[`CTRL_SCLK_ENA] = sclk_ena;
                rdata[`CTRL_CMD_LINE] = sd_cmd_sync[1];
                rdata[`CTRL_BUSY]     = i_tx_busy;
            end
            A_CMD_ARG:   rdata = arg_reg;
            A_CMD_START: begin
                rdata[5:0]            = last_index;
                rdata[`START_PENDING] = cmd_valid_q;
            end
            A_STATUS: begin
                rdata[3:0]           = 4'(i_tx_state);
                rdata[`STAT_OVERRUN] = overrun;
                rdata[15:8]          = cmd_count;
            end
            default: ;                              // holes read zero
        endcase
    end

    assign tick          = sclk_ena && (scaler_cnt == sck_div);
    assign o_sck         = level;
    assign o_sck_posedge = tick && !level;
    assign o_sck_negedge = tick && level;

    assign cmd.cmd_valid = cmd_valid_q;
    assign cmd.cmd_index = last_index;
    assign cmd.cmd_arg   = pend_arg;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            bus.resp_valid <= 1'b0;
            bus.resp_err   <= 1'b0;
            sck_div        <= '0;
            scaler_cnt     <= '0;
            sclk_ena       <= 1'b0;
            level          <= 1'b0;
            arg_reg        <= '0;
            last_index     <= '0;
            cmd_valid_q    <= 1'b0;
            overrun        <= 1'b0;
            cmd_count      <= '0;
            sd_cmd_sync    <= 2'b11;                // idle CMD line is high
        end else begin
            bus.resp_valid <= bus.req_valid;
            bus.resp_err   <= bus.req_valid && bad_acc;
            sd_cmd_sync    <= {sd_cmd_sync[0], i_sd_cmd};
            if (tick) begin
                scaler_cnt <= '0;
                level      <= !level;
            end else if (sclk_ena) begin
                scaler_cnt <= scaler_cnt + 1'b1;
            end
            if (wr_en && addr == A_SCKDIV) begin
                sck_div    <= bus.req_wdata[15:0];
                scaler_cnt <= '0;                   // restart the half period
            end
            if (wr_en && addr == A_CONTROL) begin
                sclk_ena <= bus.req_wdata[`CTRL_SCLK_ENA];
                if (bus.req_wdata[`CTRL_CLEAR_ERR]) begin
                    overrun <= 1'b0;
                end
            end
            if (wr_en && addr == A_CMD_ARG) begin
                arg_reg <= bus.req_wdata;
            end
            if (cmd_valid_q && cmd.cmd_ready) begin
                cmd_valid_q <= 1'b0;                // handed to the transmitter
            end
            if (start_wr) begin
                if (pending) begin
                    overrun <= 1'b1;                // dropped, old request kept
                end else begin
                    cmd_valid_q <= 1'b1;
                    last_index  <= bus.req_wdata[5:0];
                end
            end
            if (i_tx_done) begin
                cmd_count <= cmd_count + 1'b1;
            end
        end
    end

    // response data and latched argument
    always_ff @(posedge i_clk) begin
        bus.resp_rdata <= rdata;
        if (start_wr && !pending) begin
            pend_arg <= arg_reg;
        end
    end

endmodule

`default_nettype wire

// ==== hw/sdctrl_top.sv ====
// ================================================
// SD command controller top, APB in, CMD/CLK out
// no response path and no DAT lines
// ADDR_BITS sets the decoded window, 8..12
// ================================================
`timescale 1ns/1ps
`default_nettype none

module sdctrl_top import sdctrl_pkg::*; #(
    parameter int ADDR_BITS = 12
) (
    input  wire            i_clk,
    input  wire            i_nrst,
    input  wire            i_psel,
    input  wire            i_penable,
    input  wire            i_pwrite,
    input  wire reg_addr_t i_paddr,
    input  wire reg_data_t i_pwdata,
    output logic           o_pready,
    output reg_data_t      o_prdata,
    output logic           o_pslverr,
    input  wire            i_sd_cmd,
    output logic           o_sd_clk,
    output logic           o_sd_cmd,
    output logic           o_sd_busy
);

    logic      sck_negedge;
    logic      tx_busy;
    tx_state_t tx_state;
    logic      tx_done;

    sdctrl_bus_if bus_if ();
    sdctrl_cmd_if cmd_if ();

    sdctrl_apb_slave #(
        .ADDR_BITS (ADDR_BITS)
    ) apb_i (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_pready  (o_pready),
        .o_prdata  (o_prdata),
        .o_pslverr (o_pslverr),
        .bus       (bus_if.master)
    );

    sdctrl_regs #(
        .ADDR_BITS (ADDR_BITS)
    ) regs_i (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_sd_cmd      (i_sd_cmd),
        .bus           (bus_if.slave),
        .cmd           (cmd_if.source),
        .o_sck         (o_sd_clk),
        .o_sck_posedge (),                          // frame bits move on falling strobes only
        .o_sck_negedge (sck_negedge),
        .i_tx_busy     (tx_busy),
        .i_tx_state    (tx_state),
        .i_tx_done     (tx_done)
    );

    sdctrl_cmd_tx tx_i (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_sck_negedge (sck_negedge),
        .cmd           (cmd_if.sink),
        .o_sd_cmd      (o_sd_cmd),
        .o_busy        (tx_busy),
        .o_state       (tx_state),
        .o_done        (tx_done)
    );

    assign o_sd_busy = tx_busy;

endmodule

`default_nettype wire

// ==== include/sdctrl_map.svh ====
// ================================================
// SD host register map, byte offsets in the window
// offsets are 8 bits wide so any window >= 8 bits fits
// gaps up to REG_LAST read zero, beyond it is an error
// ================================================
`ifndef SDCTRL_MAP_SVH
`define SDCTRL_MAP_SVH

`define REG_SCKDIV      8'h00   // sck divider, RW
`define REG_CONTROL     8'h04   // enable, clear, line readback
`define REG_CMD_ARG     8'h0C   // command argument, RW
`define REG_CMD_START   8'h10   // write index to start a command
`define REG_STATUS      8'h14   // read only
`define REG_LAST        `REG_STATUS

`define CTRL_SCLK_ENA   0       // card clock enable
`define CTRL_CLEAR_ERR  1       // write 1 clears overrun, reads 0
`define CTRL_CMD_LINE   4       // CMD line level, read only
`define CTRL_BUSY       8       // transmitter busy, read only
`define START_PENDING   8       // request not yet accepted
`define STAT_OVERRUN    4       // sticky overrun flag

`endif

// ==== verilog.f ====
+incdir+include
hw/sdctrl_pkg.sv
hw/sdctrl_bus_if.sv
hw/sdctrl_apb_slave.sv
hw/sdctrl_regs.sv
hw/sdctrl_cmd_tx.sv
hw/sdctrl_top.sv
dv/sdctrl_assert.sv
dv/sdctrl_tb.sv
